/* verilog/runner_pkg.sv */
`default_nettype none

package runner_pkg;

    typedef enum logic [1:0] {
        WAITING,
        RUNNING,
        CRASHED,
        RESTARTING
    } state_t;

    // Collision box in pixels
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [11:0] w;
        logic [11:0] h;
    } box_t;

    // Game speed units per pixel per frame
    localparam int SPEED_SCALE = 1024;

    localparam int SPEED = 6 * SPEED_SCALE;
    localparam int SLOW_SPEED = 4 * SPEED_SCALE;

    localparam int MAX_SPEED = 13 * SPEED_SCALE;
    localparam int SLOW_MAX_SPEED = 9 * SPEED_SCALE;

    localparam int ACCELERATION = 1;

    localparam int SPEED_W = 15;

    localparam int MAX_NIGHT_RATE = 63;
    localparam int NIGHT_RATE_DELTA = 1;
    localparam int NIGHT_RATE_W = 6;

    localparam int TIMER_W = 6;

    localparam int RNG_W = 11;

endpackage

`default_nettype wire

/* verilog/game_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface game_if;
    import runner_pkg::*;

    // One pulse per frame
    logic update;
    logic [TIMER_W-1:0] timer;

    logic start_step;
    logic run_step;
    logic restart;

    modport stepper (output update, timer);

    modport control (input update, timer, output start_step, run_step, restart);

    modport follower (input update, timer, start_step, run_step, restart);

endinterface

`default_nettype wire

/* verilog/frame_stepper.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_stepper #(
    parameter int FPS = 60
) (
    input logic clk,
    input logic rst,
    input logic painter_finished,
    game_if.stepper gif
);
    import runner_pkg::*;

    logic painter_finished_last;
    logic frame_edge;

    assign frame_edge = painter_finished && !painter_finished_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            painter_finished_last <= 1'b0;
            gif.update <= 1'b0;
            gif.timer <= '0;
        end else begin
            painter_finished_last <= painter_finished;
            gif.update <= frame_edge;

            // Frame counter wraps once per second of frames
            if (frame_edge) begin
                if (gif.timer == TIMER_W'(FPS - 1)) begin
                    gif.timer <= '0;
                end else begin
                    gif.timer <= gif.timer + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/game_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module game_fsm #(
    parameter int RESTART_TIME = 60
) (
    input  logic clk,
    input  logic rst,
    input  logic jumping,
    input  logic crashed,
    output runner_pkg::state_t state,
    output logic rng_hold,
    game_if.control gif
);
    import runner_pkg::*;

    localparam int CNT_W = $clog2(RESTART_TIME + 1);

    state_t next_state;
    logic jumping_last;
    logic [CNT_W-1:0] restart_cnt;

    always_comb begin
        next_state = state;
        case (state)
            WAITING: if (gif.update && jumping) next_state = RUNNING;
            RUNNING: if (crashed) next_state = CRASHED;
            // Needs a fresh press once the lock-out has run out
            CRASHED: begin
                if (restart_cnt == CNT_W'(RESTART_TIME) && jumping && !jumping_last) begin
                    next_state = RESTARTING;
                end
            end
            RESTARTING: if (!jumping) next_state = WAITING;
            default: next_state = WAITING;
        endcase
    end

    assign gif.start_step = gif.update && state == WAITING && next_state == RUNNING;
    assign gif.run_step = gif.update && state == RUNNING && next_state == RUNNING;
    assign gif.restart = next_state == RESTARTING;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAITING;
            jumping_last <= 1'b0;
            restart_cnt <= '0;
            rng_hold <= 1'b1;
        end else begin
            state <= next_state;
            jumping_last <= jumping;

            if (gif.restart) begin
                restart_cnt <= '0;
            end else if (gif.update && state == CRASHED &&
                         restart_cnt != CNT_W'(RESTART_TIME)) begin
                restart_cnt <= restart_cnt + 1'b1;
            end

            // Generators free-run from the first start on
            if (gif.start_step) begin
                rng_hold <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/speed_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module speed_ctrl #(
    parameter int CLEAR_TIME = 180
) (
    input  logic clk,
    input  logic rst,
    input  logic slow,
    output logic [runner_pkg::SPEED_W-1:0] speed,
    output logic has_obstacles,
    game_if.follower gif
);
    import runner_pkg::*;

    // Saturates one past CLEAR_TIME
    localparam int CNT_W = $clog2(CLEAR_TIME + 2);

    logic [CNT_W-1:0] clear_cnt;
    logic [SPEED_W-1:0] speed_next;
    logic [SPEED_W-1:0] speed_cap;

    assign speed_next = speed + SPEED_W'(ACCELERATION);
    assign speed_cap = slow ? SPEED_W'(SLOW_MAX_SPEED) : SPEED_W'(MAX_SPEED);

    always_ff @(posedge clk) begin
        if (rst || gif.restart) begin
            speed <= '0;
            clear_cnt <= '0;
            has_obstacles <= 1'b0;
        end else if (gif.start_step) begin
            speed <= slow ? SPEED_W'(SLOW_SPEED) : SPEED_W'(SPEED);
        end else if (gif.run_step) begin
            if (clear_cnt != CNT_W'(CLEAR_TIME + 1)) begin
                clear_cnt <= clear_cnt + 1'b1;
            end
            if (clear_cnt > CNT_W'(CLEAR_TIME)) begin
                has_obstacles <= 1'b1;
            end

            // Slow mode accelerates on even frames only
            if (speed_next <= speed_cap && (!slow || !gif.timer[0])) begin
                speed <= speed_next;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/night_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module night_ctrl #(
    parameter int INVERT_FADE_DURATION = 720
) (
    input  logic clk,
    input  logic rst,
    input  logic invert_trigger,
    output logic [runner_pkg::NIGHT_RATE_W-1:0] night_rate,
    game_if.follower gif
);
    import runner_pkg::*;

    localparam int FADE_W = $clog2(INVERT_FADE_DURATION + 1);

    logic inverted;
    logic [FADE_W-1:0] fade_timer;

    always_ff @(posedge clk) begin
        if (rst || gif.restart) begin
            inverted <= 1'b0;
            fade_timer <= '0;
            night_rate <= '0;
        end else begin
            if (gif.run_step) begin
                if (fade_timer == FADE_W'(INVERT_FADE_DURATION)) begin
                    fade_timer <= '0;
                    inverted <= 1'b0;
                end else if (inverted) begin
                    fade_timer <= fade_timer + 1'b1;
                end else if (invert_trigger) begin
                    inverted <= 1'b1;
                end
            end

            // Fade in or out one step per frame
            if (gif.update) begin
                if (inverted && night_rate < NIGHT_RATE_W'(MAX_NIGHT_RATE)) begin
                    night_rate <= night_rate + NIGHT_RATE_W'(NIGHT_RATE_DELTA);
                end else if (!inverted && night_rate != '0) begin
                    night_rate <= night_rate - NIGHT_RATE_W'(NIGHT_RATE_DELTA);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/collision_check.sv */
`timescale 1ns/1ps
`default_nettype none

module collision_check #(
    parameter int OBSTACLE_BOXES = 4
) (
    input  logic clk,
    input  logic rst,
    input  runner_pkg::box_t trex_box,
    input  runner_pkg::box_t obstacle_box [OBSTACLE_BOXES],
    output logic crashed
);
    import runner_pkg::*;

    logic hit;

    // Ends computed one bit wider so edges near 4095 do not wrap
    function automatic logic overlap(input box_t a, input box_t b);
        logic empty;
        logic x_hit;
        logic y_hit;
        empty = a.w == '0 || a.h == '0 || b.w == '0 || b.h == '0;
        x_hit = 13'(a.x) < 13'(b.x) + 13'(b.w) && 13'(b.x) < 13'(a.x) + 13'(a.w);
        y_hit = 13'(a.y) < 13'(b.y) + 13'(b.h) && 13'(b.y) < 13'(a.y) + 13'(a.h);
        return !empty && x_hit && y_hit;
    endfunction

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < OBSTACLE_BOXES; i++) begin
            hit |= overlap(trex_box, obstacle_box[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crashed <= 1'b0;
        end else begin
            crashed <= hit;
        end
    end

endmodule

`default_nettype wire

/* verilog/lfsr_prng.sv */
`timescale 1ns/1ps
`default_nettype none

module lfsr_prng #(
    parameter int SEED_OFFSET = 0
) (
    input  logic clk,
    input  logic hold,
    input  logic [runner_pkg::RNG_W-1:0] seed_base,
    game_if.follower gif,
    output logic [runner_pkg::RNG_W-1:0] data
);
    import runner_pkg::*;

    logic feedback;

    // Taps 11 and 9 for maximal length
    assign feedback = data[RNG_W-1] ^ data[RNG_W-3];

    always_ff @(posedge clk) begin
        if (hold) begin
            // Frame timer mixes in the moment the game starts
            data <= seed_base + RNG_W'(gif.timer) + RNG_W'(SEED_OFFSET);
        end else begin
            data <= {data[RNG_W-2:0], feedback};
        end
    end

endmodule

`default_nettype wire

/* verilog/runner_top.sv */
`timescale 1ns/1ps
`default_nettype none

module runner_top #(
    parameter int FPS = 60,
    parameter int CLEAR_TIME = 180,
    parameter int RESTART_TIME = 60,
    parameter int INVERT_FADE_DURATION = 720,
    parameter int OBSTACLE_BOXES = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic slow,
    input  logic jumping,
    input  logic painter_finished,
    input  logic invert_trigger,
    input  logic [runner_pkg::RNG_W-1:0] random_seed,
    input  runner_pkg::box_t trex_box,
    input  runner_pkg::box_t obstacle_box [OBSTACLE_BOXES],
    output runner_pkg::state_t state,
    output logic [runner_pkg::SPEED_W-1:0] speed,
    output logic has_obstacles,
    output logic [runner_pkg::NIGHT_RATE_W-1:0] night_rate,
    output logic update,
    output logic [runner_pkg::RNG_W-1:0] rng_data,
    output logic [runner_pkg::RNG_W-1:0] rng_data2
);
    import runner_pkg::*;

    game_if gif ();

    logic crashed;
    logic rng_hold;

    assign update = gif.update;

    frame_stepper #(.FPS(FPS)) u_stepper (
        .clk, .rst, .painter_finished, .gif(gif.stepper)
    );

    game_fsm #(.RESTART_TIME(RESTART_TIME)) u_fsm (
        .clk, .rst, .jumping, .crashed, .state, .rng_hold, .gif(gif.control)
    );

    speed_ctrl #(.CLEAR_TIME(CLEAR_TIME)) u_speed (
        .clk, .rst, .slow, .speed, .has_obstacles, .gif(gif.follower)
    );

    night_ctrl #(.INVERT_FADE_DURATION(INVERT_FADE_DURATION)) u_night (
        .clk, .rst, .invert_trigger, .night_rate, .gif(gif.follower)
    );

    collision_check #(.OBSTACLE_BOXES(OBSTACLE_BOXES)) u_collision (
        .clk, .rst, .trex_box, .obstacle_box, .crashed
    );

    // Two gap generators with seeds one apart
    lfsr_prng #(.SEED_OFFSET(0)) prng_gap (
        .clk, .hold(rng_hold), .seed_base(random_seed), .gif(gif.follower), .data(rng_data)
    );

    lfsr_prng #(.SEED_OFFSET(1)) prng_gap2 (
        .clk, .hold(rng_hold), .seed_base(random_seed), .gif(gif.follower), .data(rng_data2)
    );

endmodule

`default_nettype wire

/* verif/runner_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module runner_sva (
    input logic clk,
    input logic rst,
    input logic update,
    input logic start_step,
    input logic run_step,
    input runner_pkg::state_t state
);
    import runner_pkg::*;

    // A frame pulse lasts one cycle
    a_update_single: assert property (@(posedge clk) disable iff (rst)
        update |=> !update)
        else $error("update high on two consecutive cycles");

    a_steps_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(start_step && run_step))
        else $error("start_step and run_step high together");

    // Only a restart leaves the crashed state
    a_crash_exit: assert property (@(posedge clk) disable iff (rst)
        state == CRASHED |=> state == CRASHED || state == RESTARTING)
        else $error("state left CRASHED for a state other than RESTARTING");

endmodule

bind game_fsm runner_sva u_sva (
    .clk(clk),
    .rst(rst),
    .update(gif.update),
    .start_step(gif.start_step),
    .run_step(gif.run_step),
    .state(state)
);

`default_nettype wire

/* verif/tb_runner.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_runner;
    import runner_pkg::*;

    localparam int FPS = 8;
    localparam int CLEAR_TIME = 5;
    localparam int RESTART_TIME = 3;
    localparam int INVERT_FADE_DURATION = 6;
    localparam int OBSTACLE_BOXES = 4;
    localparam int FIELDS = 11;

    logic clk;
    logic rst;
    logic slow;
    logic jumping;
    logic painter_finished;
    logic invert_trigger;
    logic [RNG_W-1:0] random_seed;
    box_t trex_box;
    box_t obstacle_box [OBSTACLE_BOXES];
    state_t state;
    logic [SPEED_W-1:0] speed;
    logic has_obstacles;
    logic [NIGHT_RATE_W-1:0] night_rate;
    logic update;
    logic [RNG_W-1:0] rng_data;
    logic [RNG_W-1:0] rng_data2;

    string names[$];
    int fields[$];
    string test_name;
    logic [31:0] rng_state;
    int cycles;
    int cycle_limit;
    int fail_count;
    logic gen_free;
    logic [RNG_W-1:0] prev_rng;
    logic [RNG_W-1:0] prev_rng2;

    // Reference model state
    state_t m_state;
    int m_speed;
    int m_frames;
    int m_crash_frames;
    logic m_last_jump;

    runner_top #(
        .FPS(FPS),
        .CLEAR_TIME(CLEAR_TIME),
        .RESTART_TIME(RESTART_TIME),
        .INVERT_FADE_DURATION(INVERT_FADE_DURATION),
        .OBSTACLE_BOXES(OBSTACLE_BOXES)
    ) DUT (
        .clk, .rst, .slow, .jumping, .painter_finished, .invert_trigger, .random_seed,
        .trex_box, .obstacle_box, .state, .speed, .has_obstacles, .night_rate, .update,
        .rng_data, .rng_data2
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout reached after %0d cycles before all tests finished", cycles);
            $display("FAIL: see errors above");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // x^11 + x^9 + 1
    function automatic logic [RNG_W-1:0] lfsr_step(input logic [RNG_W-1:0] v);
        return {v[RNG_W-2:0], v[10] ^ v[8]};
    endfunction

    function automatic logic boxes_overlap(input box_t a, input box_t b);
        int a_end_x;
        int b_end_x;
        int a_end_y;
        int b_end_y;
        if (a.w == 0 || a.h == 0 || b.w == 0 || b.h == 0) begin
            return 1'b0;
        end
        a_end_x = a.x + a.w;
        b_end_x = b.x + b.w;
        a_end_y = a.y + a.h;
        b_end_y = b.y + b.h;
        return a.x < b_end_x && b.x < a_end_x && a.y < b_end_y && b.y < a_end_y;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_count++;
            $display("Mismatch in %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // Generators held at seed plus frame timer
    task automatic check_held_rng();
        logic [RNG_W-1:0] base;
        logic [RNG_W-1:0] base2;
        base = random_seed + RNG_W'(m_frames % FPS);
        base2 = base + 1'b1;
        check_value("rng_data", base, rng_data);
        check_value("rng_data2", base2, rng_data2);
    endtask

    task automatic model_frame();
        int timer;
        int cap;
        m_frames++;
        timer = m_frames % FPS;
        cap = slow ? SLOW_MAX_SPEED : MAX_SPEED;
        if (m_state == WAITING && jumping) begin
            m_state = RUNNING;
            m_speed = slow ? SLOW_SPEED : SPEED;
        end else if (m_state == RUNNING) begin
            if ((!slow || timer % 2 == 0) && m_speed + ACCELERATION <= cap) begin
                m_speed += ACCELERATION;
            end
        end else if (m_state == CRASHED && m_crash_frames < RESTART_TIME) begin
            m_crash_frames++;
        end
    endtask

    task automatic run_frame();
        logic [31:0] gap;
        rng_state = xorshift(rng_state);
        gap = 1 + rng_state % 3;
        repeat (gap) @(posedge clk);
        #2;
        painter_finished = 1'b1;
        @(negedge clk);
        while (!update) @(negedge clk);
        @(posedge clk);
        #2;
        painter_finished = 1'b0;
        @(negedge clk);
        model_frame();
        if (!gen_free) begin
            check_held_rng();
            if (m_state == RUNNING) begin
                #1 gen_free = 1'b1;
            end
        end
    endtask

    task automatic run_line(input int idx);
        int base;
        int frames;
        logic hit;
        box_t box0;
        base = idx * FIELDS;
        test_name = names[idx];
        frames = fields[base];
        @(posedge clk);
        #2;
        slow = fields[base+1] != 0;
        jumping = fields[base+2] != 0;
        invert_trigger = fields[base+3] != 0;
        box0.x = 12'(fields[base+4]);
        box0.y = 12'(fields[base+5]);
        box0.w = 12'(fields[base+6]);
        box0.h = 12'(fields[base+7]);
        obstacle_box[0] = box0;
        hit = 1'b0;
        for (int i = 0; i < OBSTACLE_BOXES; i++) begin
            hit |= boxes_overlap(trex_box, obstacle_box[i]);
        end
        // Transitions that follow input changes rather than frames
        if (m_state == RUNNING && hit) begin
            m_state = CRASHED;
        end else if (m_state == CRASHED && jumping && !m_last_jump &&
                     m_crash_frames == RESTART_TIME) begin
            m_state = RESTARTING;
            m_speed = 0;
            m_crash_frames = 0;
        end else if (m_state == RESTARTING && !jumping) begin
            m_state = WAITING;
        end
        m_last_jump = jumping;
        repeat (2) @(posedge clk);
        repeat (frames) run_frame();
        if (frames == 0) begin
            @(negedge clk);
        end
        check_value("state", fields[base+8], state);
        check_value("model state", fields[base+8], m_state);
        check_value("speed", m_speed, speed);
        check_value("has_obstacles", fields[base+9], has_obstacles);
        check_value("night_rate", fields[base+10], night_rate);
    endtask

    // Once free-running, every cycle is one LFSR step
    always @(negedge clk) begin
        if (gen_free) begin
            check_value("rng_data step", lfsr_step(prev_rng), rng_data);
            check_value("rng_data2 step", lfsr_step(prev_rng2), rng_data2);
        end
        prev_rng = rng_data;
        prev_rng2 = rng_data2;
    end

    initial begin
        int fd;
        int n;
        int total;
        string line;
        string name;
        int v [FIELDS];
        clk = 1'b0;
        rst = 1'b1;
        slow = 1'b0;
        jumping = 1'b0;
        painter_finished = 1'b0;
        invert_trigger = 1'b0;
        rng_state = xorshift(32'hf799);
        random_seed = rng_state[RNG_W-1:0];
        trex_box = '{12'd20, 12'd100, 12'd40, 12'd40};
        obstacle_box[0] = '{12'd300, 12'd100, 12'd20, 12'd30};
        obstacle_box[1] = '{12'd400, 12'd100, 12'd20, 12'd30};
        obstacle_box[2] = '{12'd30, 12'd110, 12'd0, 12'd20};
        obstacle_box[3] = '{12'd30, 12'd110, 12'd20, 12'd0};
        cycles = 0;
        cycle_limit = 0;
        fail_count = 0;
        gen_free = 1'b0;
        m_state = WAITING;
        m_speed = 0;
        m_frames = 0;
        m_crash_frames = 0;
        m_last_jump = 1'b0;
        test_name = "reset";

        fd = $fopen("verif/runner_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/runner_stim.txt");
            $display("FAIL: see errors above");
            $fatal(1, "No stimulus");
        end
        total = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", name, v[0], v[1],
                            v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
                if (n == FIELDS + 1) begin
                    names.push_back(name);
                    for (int k = 0; k < FIELDS; k++) begin
                        fields.push_back(v[k]);
                    end
                    total += v[0];
                end else if (n > 0) begin
                    $display("Stimulus line could not be parsed: %s", line);
                    $display("FAIL: see errors above");
                    $fatal(1, "Bad stimulus");
                end
            end
        end
        $fclose(fd);
        cycle_limit = 50 * total;

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("state", WAITING, state);
        check_value("speed", 0, speed);
        check_value("has_obstacles", 0, has_obstacles);
        check_value("night_rate", 0, night_rate);
        check_value("update", 0, update);
        check_held_rng();

        for (int i = 0; i < names.size(); i++) begin
            run_line(i);
        end

        if (fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "Checks failed");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/runner_pkg.sv
verilog/game_if.sv
verilog/frame_stepper.sv
verilog/game_fsm.sv
verilog/speed_ctrl.sv
verilog/night_ctrl.sv
verilog/collision_check.sv
verilog/lfsr_prng.sv
verilog/runner_top.sv
verif/runner_sva.sv
verif/tb_runner.sv

/* verif/runner_stim.txt */
# name frames slow jumping invert_trigger obs_x obs_y obs_w obs_h
#   then expected: state(0 wait,1 run,2 crash,3 restart) has_obstacles night_rate
wait_idle    3 0 0 0 300 100 20 30 0 0 0
start        1 0 1 0 300 100 20 30 1 0 0
ramp         4 0 1 0 300 100 20 30 1 0 0
ramp_clear   2 0 1 0 300 100 20 30 1 0 0
obstacles_on 1 0 1 0 300 100 20 30 1 1 0
zero_width   2 0 1 0  30 110  0 20 1 1 0
touching     1 0 1 0  60 100 20 30 1 1 0
night_on     3 0 1 1 300 100 20 30 1 1 2
night_fade   6 0 1 0 300 100 20 30 1 1 6
crash        2 0 0 0  30 110 20 20 2 1 4
early_jump   1 0 1 0 300 100 20 30 2 1 3
held_jump    1 0 1 0 300 100 20 30 2 1 2
release      0 0 0 0 300 100 20 30 2 1 2
restart      1 0 1 0 300 100 20 30 3 0 0
back_wait    1 0 0 0 300 100 20 30 0 0 0
slow_start   1 1 1 0 300 100 20 30 1 0 0
slow_ramp    5 1 1 0 300 100 20 30 1 0 0
